// File: hw/tcb_pkg.sv
//////////////////////////////
// bus width types for the TCB port
// address, data and byte enable vectors
// response delay default and legal range
//////////////////////////////

package tcb_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // byte address, 4 KiB space
  localparam int unsigned ADR_W = 12;
  // data word
  localparam int unsigned DAT_W = 32;
  // one enable per byte lane
  localparam int unsigned BEN_W = DAT_W / 8;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [ADR_W-1:0] adr_t;
  typedef logic [DAT_W-1:0] dat_t;
  typedef logic [BEN_W-1:0] ben_t;

  //////////////////////////////
  // response delay
  //////////////////////////////

  // cycles from transfer edge to response
  localparam int unsigned DLY_DEF = 1;
  // supported range
  localparam int unsigned DLY_MIN = 1;
  localparam int unsigned DLY_MAX = 3;

endpackage

// File: hw/tcb_map_pkg.sv
//////////////////////////////
// memory map of the subsystem
// window bases and sizes, register offsets
// ID constant, stall FSM states
//////////////////////////////

package tcb_map_pkg;

  // memory window 0x000..0x3ff
  localparam tcb_pkg::adr_t MEM_BASE = 12'h000;
  localparam tcb_pkg::adr_t MEM_SPAN = 12'h400;

  // register window 0x400..0x40f
  localparam tcb_pkg::adr_t CFG_BASE = 12'h400;
  localparam tcb_pkg::adr_t CFG_SPAN = 12'h010;

  //////////////////////////////
  // register offsets
  //////////////////////////////

  localparam logic [3:0] REG_ID      = 4'h0;
  localparam logic [3:0] REG_STALL   = 4'h4;
  localparam logic [3:0] REG_SCRATCH = 4'h8;
  localparam logic [3:0] REG_COUNT   = 4'hc;

  // read-only identification word
  localparam tcb_pkg::dat_t CFG_ID = 32'h7cb0_0001;

  // stall period field width
  localparam int unsigned STALL_W = 4;

  // memory back-pressure FSM
  typedef enum logic [0:0] {
    ST_RUN,
    ST_STALL
  } stall_state_t;

endpackage

// File: hw/tcb_dec.sv
//////////////////////////////
// TCB address decoder
// window select, unmapped error flag
// delayed select and response mux
//////////////////////////////

`timescale 1ns/10ps

module tcb_dec #(
  parameter int unsigned DLY = tcb_pkg::DLY_DEF
) (
  input  logic          tcb,
  input  logic          arst_n_i,
  // request from manager
  input  logic          vld_i,
  input  tcb_pkg::adr_t adr_i,
  // subordinate side
  input  logic          mem_rdy_i,
  input  tcb_pkg::dat_t mem_rdt_i,
  input  tcb_pkg::dat_t cfg_rdt_i,
  output logic          mem_vld_o,
  output logic          cfg_vld_o,
  // response to manager
  output logic          rdy_o,
  output tcb_pkg::dat_t rdt_o,
  output logic          err_o
);

  //////////////////////////////
  // address decode
  //////////////////////////////

  // offsets into each window, wrap makes one compare enough
  tcb_pkg::adr_t mem_ofs;
  tcb_pkg::adr_t cfg_ofs;
  logic          mem_hit;
  logic          cfg_hit;
  logic          unm;
  logic          trn;

  // select and error flag, one bit per delay stage
  logic [DLY-1:0] sel_mem_pipe;
  logic [DLY-1:0] unm_pipe;

  assign mem_ofs = adr_i - tcb_map_pkg::MEM_BASE;
  assign cfg_ofs = adr_i - tcb_map_pkg::CFG_BASE;
  assign mem_hit = (mem_ofs < tcb_map_pkg::MEM_SPAN);
  assign cfg_hit = (cfg_ofs < tcb_map_pkg::CFG_SPAN);
  assign unm     = !mem_hit && !cfg_hit;

  // gate vld to the selected subordinate only
  assign mem_vld_o = vld_i && mem_hit;
  assign cfg_vld_o = vld_i && cfg_hit;

  // registers and unmapped space are always ready
  assign rdy_o = mem_hit ? mem_rdy_i : 1'b1;
  assign trn   = vld_i && rdy_o;

  //////////////////////////////
  // response alignment
  //////////////////////////////

  always_ff @(posedge tcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_mem_pipe <= '0;
      unm_pipe     <= '0;
    end else begin
      // select only moves on a transfer, so rdt holds between slots
      if (trn) begin
        sel_mem_pipe[0] <= mem_hit;
      end
      // error flag is a single-slot pulse
      unm_pipe[0] <= trn && unm;
      for (int i = 1; i < DLY; i++) begin
        sel_mem_pipe[i] <= sel_mem_pipe[i-1];
        unm_pipe[i]     <= unm_pipe[i-1];
      end
    end
  end

  // response mux, DLY cycles after the transfer
  assign rdt_o = sel_mem_pipe[DLY-1] ? mem_rdt_i : cfg_rdt_i;
  assign err_o = unm_pipe[DLY-1];

  //////////////////////////////
  // checks
  //////////////////////////////

  // windows must not overlap
  a_one_hot_vld: assert property (
    @(posedge tcb) disable iff (!arst_n_i)
    !(mem_vld_o && cfg_vld_o)
  );

endmodule

// File: hw/tcb_mem_sub.sv
//////////////////////////////
// TCB memory subordinate
// 256 words, byte-enabled writes
// delayed read pipeline, stall FSM
//////////////////////////////

`timescale 1ns/10ps

module tcb_mem_sub #(
  parameter int unsigned DLY = tcb_pkg::DLY_DEF
) (
  input  logic                               tcb,
  input  logic                               arst_n_i,
  // request
  input  logic                               vld_i,
  input  logic                               wen_i,
  input  tcb_pkg::adr_t                      adr_i,
  input  tcb_pkg::ben_t                      ben_i,
  input  tcb_pkg::dat_t                      wdt_i,
  // back-pressure period from the register block
  input  logic [tcb_map_pkg::STALL_W-1:0]    stall_prd_i,
  // handshake and response
  output logic                               rdy_o,
  output tcb_pkg::dat_t                      rdt_o,
  // transfer pulse for the counter
  output logic                               trn_o
);

  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned IDX_W     = $clog2(MEM_WORDS);

  //////////////////////////////
  // local signals
  //////////////////////////////

  tcb_pkg::dat_t mem [0:MEM_WORDS-1];

  tcb_pkg::adr_t    mem_ofs;
  logic [IDX_W-1:0] idx;
  logic             trn;

  // read data, one entry per delay stage
  tcb_pkg::dat_t rdt_pipe [0:DLY-1];

  // stall FSM
  tcb_map_pkg::stall_state_t state;
  logic [tcb_map_pkg::STALL_W-1:0] cnt;
  logic [tcb_map_pkg::STALL_W:0]   cnt_nxt;
  logic                            prd_hit;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // word index inside the window
  assign mem_ofs = adr_i - tcb_map_pkg::MEM_BASE;
  assign idx     = mem_ofs[IDX_W+1:2];

  // ready in every cycle except the stall cycle
  assign rdy_o = (state == tcb_map_pkg::ST_RUN);
  assign trn   = vld_i && rdy_o;
  assign trn_o = trn;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (trn && wen_i) begin
      // only enabled lanes change
      for (int b = 0; b < tcb_pkg::BEN_W; b++) begin
        if (ben_i[b]) begin
          mem[idx][8*b +: 8] <= wdt_i[8*b +: 8];
        end
      end
    end
  end

  // read pipeline
  // stage 0 loads on a transfer, later stages follow
  // so the output only changes in a response slot
  always_ff @(posedge tcb) begin
    if (trn) begin
      rdt_pipe[0] <= mem[idx];
    end
    for (int i = 1; i < DLY; i++) begin
      rdt_pipe[i] <= rdt_pipe[i-1];
    end
  end

  assign rdt_o = rdt_pipe[DLY-1];

  //////////////////////////////
  // stall FSM
  //////////////////////////////

  // transfers including this one
  assign cnt_nxt = {1'b0, cnt} + 1'b1;
  // zero period turns stalling off
  assign prd_hit = (stall_prd_i != '0) && (cnt_nxt >= {1'b0, stall_prd_i});

  always_ff @(posedge tcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= tcb_map_pkg::ST_RUN;
      cnt   <= '0;
    end else begin
      case (state)
        tcb_map_pkg::ST_RUN: begin
          if (trn) begin
            if (prd_hit) begin
              // period reached, drop rdy next cycle
              state <= tcb_map_pkg::ST_STALL;
              cnt   <= '0;
            end else begin
              cnt <= cnt_nxt[tcb_map_pkg::STALL_W-1:0];
            end
          end
        end
        // single stall cycle
        tcb_map_pkg::ST_STALL: begin
          state <= tcb_map_pkg::ST_RUN;
        end
        default: begin
          state <= tcb_map_pkg::ST_RUN;
        end
      endcase
    end
  end

  // stall cycle accepts nothing
  a_no_trn_in_stall: assert property (
    @(posedge tcb) disable iff (!arst_n_i)
    (state == tcb_map_pkg::ST_STALL) |-> !trn_o
  );

endmodule

// File: hw/tcb_cfg_regs.sv
//////////////////////////////
// TCB configuration registers
// ID, stall period, scratch
// memory transfer counter
//////////////////////////////

`timescale 1ns/10ps

module tcb_cfg_regs #(
  parameter int unsigned DLY = tcb_pkg::DLY_DEF
) (
  input  logic                            tcb,
  input  logic                            arst_n_i,
  // request, never stalled
  input  logic                            vld_i,
  input  logic                            wen_i,
  input  tcb_pkg::adr_t                   adr_i,
  input  tcb_pkg::ben_t                   ben_i,
  input  tcb_pkg::dat_t                   wdt_i,
  // transfer pulse from the memory
  input  logic                            mem_trn_i,
  // response and memory control
  output tcb_pkg::dat_t                   rdt_o,
  output logic [tcb_map_pkg::STALL_W-1:0] stall_prd_o
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // word-aligned register offset
  logic [3:0] ofs;
  logic       wr;

  logic [tcb_map_pkg::STALL_W-1:0] stall_q;
  tcb_pkg::dat_t                   scratch_q;
  tcb_pkg::dat_t                   count_q;
  tcb_pkg::dat_t                   rd_mux;
  tcb_pkg::dat_t                   rdt_pipe [0:DLY-1];

  assign ofs = {adr_i[3:2], 2'b00};
  assign wr  = vld_i && wen_i;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge tcb or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stall_q   <= '0;
      scratch_q <= '0;
      count_q   <= '0;
    end else begin
      // stall period lives in byte 0
      if (wr && (ofs == tcb_map_pkg::REG_STALL) && ben_i[0]) begin
        stall_q <= wdt_i[tcb_map_pkg::STALL_W-1:0];
      end
      if (wr && (ofs == tcb_map_pkg::REG_SCRATCH)) begin
        for (int b = 0; b < tcb_pkg::BEN_W; b++) begin
          if (ben_i[b]) begin
            scratch_q[8*b +: 8] <= wdt_i[8*b +: 8];
          end
        end
      end
      // free running, wraps at 32 bits
      if (mem_trn_i) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign stall_prd_o = stall_q;

  // read select
  always_comb begin
    case (ofs)
      tcb_map_pkg::REG_ID:      rd_mux = tcb_map_pkg::CFG_ID;
      tcb_map_pkg::REG_STALL:   rd_mux = tcb_pkg::dat_t'(stall_q);
      tcb_map_pkg::REG_SCRATCH: rd_mux = scratch_q;
      tcb_map_pkg::REG_COUNT:   rd_mux = count_q;
      default:                  rd_mux = '0;
    endcase
  end

  // response pipeline, holds between slots
  always_ff @(posedge tcb) begin
    if (vld_i) begin
      rdt_pipe[0] <= rd_mux;
    end
    for (int i = 1; i < DLY; i++) begin
      rdt_pipe[i] <= rdt_pipe[i-1];
    end
  end

  assign rdt_o = rdt_pipe[DLY-1];

  // period steers the memory FSM, must never go X
  a_stall_known: assert property (
    @(posedge tcb) disable iff (!arst_n_i)
    !$isunknown(stall_prd_o)
  );

endmodule

// File: hw/tcb_sub_top.sv
//////////////////////////////
// TCB subsystem top level
// decoder, memory, register block
//////////////////////////////

`timescale 1ns/10ps

module tcb_sub_top #(
  parameter int unsigned DLY = tcb_pkg::DLY_DEF
) (
  input  logic          tcb,
  input  logic          arst_n_i,
  // request
  input  logic          vld_i,
  input  logic          wen_i,
  input  tcb_pkg::adr_t adr_i,
  input  tcb_pkg::ben_t ben_i,
  input  tcb_pkg::dat_t wdt_i,
  // response
  output logic          rdy_o,
  output tcb_pkg::dat_t rdt_o,
  output logic          err_o
);

  // delay outside the supported range is a build error
  if ((DLY < tcb_pkg::DLY_MIN) || (DLY > tcb_pkg::DLY_MAX)) begin : g_dly_chk
    $error("DLY out of range");
  end

  //////////////////////////////
  // internal wiring
  //////////////////////////////

  logic                            mem_vld;
  logic                            cfg_vld;
  logic                            mem_rdy;
  logic                            mem_trn;
  tcb_pkg::dat_t                   mem_rdt;
  tcb_pkg::dat_t                   cfg_rdt;
  logic [tcb_map_pkg::STALL_W-1:0] stall_prd;

  // address decode and response mux
  tcb_dec #(
    .DLY (DLY)
  ) u_dec (
    .tcb       (tcb),
    .arst_n_i  (arst_n_i),
    .vld_i     (vld_i),
    .adr_i     (adr_i),
    .mem_rdy_i (mem_rdy),
    .mem_rdt_i (mem_rdt),
    .cfg_rdt_i (cfg_rdt),
    .mem_vld_o (mem_vld),
    .cfg_vld_o (cfg_vld),
    .rdy_o     (rdy_o),
    .rdt_o     (rdt_o),
    .err_o     (err_o)
  );

  // memory, stalls on the programmed period
  tcb_mem_sub #(
    .DLY (DLY)
  ) u_mem (
    .tcb         (tcb),
    .arst_n_i    (arst_n_i),
    .vld_i       (mem_vld),
    .wen_i       (wen_i),
    .adr_i       (adr_i),
    .ben_i       (ben_i),
    .wdt_i       (wdt_i),
    .stall_prd_i (stall_prd),
    .rdy_o       (mem_rdy),
    .rdt_o       (mem_rdt),
    .trn_o       (mem_trn)
  );

  // registers, count memory transfers
  tcb_cfg_regs #(
    .DLY (DLY)
  ) u_cfg (
    .tcb         (tcb),
    .arst_n_i    (arst_n_i),
    .vld_i       (cfg_vld),
    .wen_i       (wen_i),
    .adr_i       (adr_i),
    .ben_i       (ben_i),
    .wdt_i       (wdt_i),
    .mem_trn_i   (mem_trn),
    .rdt_o       (cfg_rdt),
    .stall_prd_o (stall_prd)
  );

endmodule

// File: sim/tcb_sub_tb.sv
//////////////////////////////
// testbench for the TCB subsystem
// stimulus table with shadow memory
// response checker, timeout, report
//////////////////////////////

`timescale 1ns/10ps

module tcb_sub_tb;

  localparam int unsigned DLY = tcb_pkg::DLY_DEF;

  // dut ports
  logic          tcb;
  logic          arst_n_i;
  logic          vld_i;
  logic          wen_i;
  tcb_pkg::adr_t adr_i;
  tcb_pkg::ben_t ben_i;
  tcb_pkg::dat_t wdt_i;
  logic          rdy_o;
  tcb_pkg::dat_t rdt_o;
  logic          err_o;

  // stimulus table, one entry per transfer
  logic          tbl_wen [$];
  tcb_pkg::adr_t tbl_adr [$];
  tcb_pkg::ben_t tbl_ben [$];
  tcb_pkg::dat_t tbl_wdt [$];
  tcb_pkg::dat_t tbl_rdt [$];
  logic          tbl_err [$];
  logic          tbl_chk [$];

  // responses still in flight
  int unsigned   due_q [$];
  tcb_pkg::dat_t rdt_q [$];
  logic          err_q [$];
  logic          chk_q [$];

  // word image of the memory, built with the table
  tcb_pkg::dat_t shadow [0:255];
  int unsigned   mem_count;
  int unsigned   lcg_state;
  int unsigned   cyc;
  int unsigned   limit;
  int unsigned   stall_cyc;
  int unsigned   mismatch_cnt;
  int unsigned   fail_cnt;

  tcb_sub_top #(
    .DLY (DLY)
  ) dut_i (
    .tcb      (tcb),
    .arst_n_i (arst_n_i),
    .vld_i    (vld_i),
    .wen_i    (wen_i),
    .adr_i    (adr_i),
    .ben_i    (ben_i),
    .wdt_i    (wdt_i),
    .rdy_o    (rdy_o),
    .rdt_o    (rdt_o),
    .err_o    (err_o)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // enabled lanes take the new byte
  function automatic tcb_pkg::dat_t merge_bytes(input tcb_pkg::dat_t old,
                                                input tcb_pkg::dat_t wdt,
                                                input tcb_pkg::ben_t ben);
    tcb_pkg::dat_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) begin
        res[8*b +: 8] = wdt[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic tcb_pkg::adr_t reg_adr(input logic [3:0] ofs);
    return tcb_map_pkg::CFG_BASE + tcb_pkg::adr_t'(ofs);
  endfunction

  task automatic report_mismatch(input string name, input tcb_pkg::dat_t exp,
                                 input tcb_pkg::dat_t got);
    mismatch_cnt++;
    $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
  endtask

  // err follows from the two windows
  task automatic add_entry(input logic wen, input tcb_pkg::adr_t adr,
                           input tcb_pkg::ben_t ben, input tcb_pkg::dat_t wdt,
                           input tcb_pkg::dat_t rdt, input logic chk);
    logic is_mem;
    logic is_cfg;
    is_mem = (int'(adr) >= int'(tcb_map_pkg::MEM_BASE)) &&
             (int'(adr) < int'(tcb_map_pkg::MEM_BASE) + int'(tcb_map_pkg::MEM_SPAN));
    is_cfg = (int'(adr) >= int'(tcb_map_pkg::CFG_BASE)) &&
             (int'(adr) < int'(tcb_map_pkg::CFG_BASE) + int'(tcb_map_pkg::CFG_SPAN));
    if (is_mem) begin
      mem_count++;
    end
    tbl_wen.push_back(wen);
    tbl_adr.push_back(adr);
    tbl_ben.push_back(ben);
    tbl_wdt.push_back(wdt);
    tbl_rdt.push_back(rdt);
    tbl_err.push_back(!is_mem && !is_cfg);
    tbl_chk.push_back(chk);
  endtask

  task automatic mem_write(input tcb_pkg::adr_t adr, input tcb_pkg::ben_t ben,
                           input tcb_pkg::dat_t wdt);
    shadow[adr[9:2]] = merge_bytes(shadow[adr[9:2]], wdt, ben);
    add_entry(1'b1, adr, ben, wdt, '0, 1'b0);
  endtask

  task automatic mem_read(input tcb_pkg::adr_t adr);
    add_entry(1'b0, adr, 4'hf, '0, shadow[adr[9:2]], 1'b1);
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic build_table();
    // full words, then back-to-back reads
    mem_write(12'h000, 4'hf, 32'h1122_3344);
    mem_write(12'h004, 4'hf, 32'h5566_7788);
    mem_write(12'h3fc, 4'hf, 32'ha5a5_5a5a);
    mem_write(12'h010, 4'hf, 32'hcafe_f00d);
    mem_read(12'h000);
    mem_read(12'h004);
    mem_read(12'h3fc);
    mem_read(12'h010);
    // lanes 0 and 2 only
    mem_write(12'h004, 4'b0101, 32'haabb_ccdd);
    mem_read(12'h004);
    // register block, ID ignores the write
    add_entry(1'b0, reg_adr(tcb_map_pkg::REG_ID), 4'hf, '0, tcb_map_pkg::CFG_ID, 1'b1);
    add_entry(1'b1, reg_adr(tcb_map_pkg::REG_SCRATCH), 4'hf, 32'h1234_abcd, '0, 1'b0);
    add_entry(1'b0, reg_adr(tcb_map_pkg::REG_SCRATCH), 4'hf, '0, 32'h1234_abcd, 1'b1);
    add_entry(1'b1, reg_adr(tcb_map_pkg::REG_ID), 4'hf, 32'hffff_ffff, '0, 1'b0);
    add_entry(1'b0, reg_adr(tcb_map_pkg::REG_ID), 4'hf, '0, tcb_map_pkg::CFG_ID, 1'b1);
    add_entry(1'b0, reg_adr(tcb_map_pkg::REG_COUNT), 4'hf, '0, mem_count, 1'b1);
    // unmapped space, then a mapped read
    add_entry(1'b0, 12'h800, 4'hf, '0, '0, 1'b0);
    add_entry(1'b1, 12'h800, 4'hf, 32'hdead_beef, '0, 1'b0);
    mem_read(12'h000);
    // stall every 2 memory transfers
    add_entry(1'b1, reg_adr(tcb_map_pkg::REG_STALL), 4'h1, 32'h2, '0, 1'b0);
    add_entry(1'b0, reg_adr(tcb_map_pkg::REG_STALL), 4'hf, '0, 32'h2, 1'b1);
    for (int i = 0; i < 12; i++) begin
      mem_write(12'h100 + tcb_pkg::adr_t'(4 * i), 4'hf, lcg_next());
    end
    for (int i = 0; i < 12; i++) begin
      mem_read(12'h100 + tcb_pkg::adr_t'(4 * i));
    end
    add_entry(1'b0, reg_adr(tcb_map_pkg::REG_COUNT), 4'hf, '0, mem_count, 1'b1);
  endtask

  // hold each request until rdy, note when its response is due
  task automatic drive_table();
    for (int i = 0; i < tbl_wen.size(); i++) begin
      vld_i <= 1'b1;
      wen_i <= tbl_wen[i];
      adr_i <= tbl_adr[i];
      ben_i <= tbl_ben[i];
      wdt_i <= tbl_wdt[i];
      @(negedge tcb);
      while (!rdy_o) begin
        @(negedge tcb);
      end
      // transfer on the next edge
      due_q.push_back(cyc + DLY);
      rdt_q.push_back(tbl_rdt[i]);
      err_q.push_back(tbl_err[i]);
      chk_q.push_back(tbl_chk[i]);
      @(posedge tcb);
    end
    vld_i <= 1'b0;
    wen_i <= 1'b0;
  endtask

  //////////////////////////////
  // clock, counters, checker
  //////////////////////////////

  initial tcb = 1'b0;
  always #2 tcb = ~tcb;

  always @(posedge tcb) begin
    cyc <= cyc + 1;
  end

  always @(negedge tcb) begin
    if (arst_n_i && vld_i && !rdy_o) begin
      stall_cyc++;
    end
  end

  // response slot checks
  always @(negedge tcb) begin
    if ((due_q.size() != 0) && (due_q[0] == cyc)) begin
      if (err_o !== err_q[0]) begin
        report_mismatch("err_o", tcb_pkg::dat_t'(err_q[0]), tcb_pkg::dat_t'(err_o));
      end
      if (chk_q[0] && (rdt_o !== rdt_q[0])) begin
        report_mismatch("rdt_o", rdt_q[0], rdt_o);
      end
      void'(due_q.pop_front());
      void'(rdt_q.pop_front());
      void'(err_q.pop_front());
      void'(chk_q.pop_front());
    end
  end

  initial begin
    wait ((limit != 0) && (cyc >= limit));
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////

  initial begin
    arst_n_i     = 1'b0;
    vld_i        = 1'b0;
    wen_i        = 1'b0;
    adr_i        = '0;
    ben_i        = '0;
    wdt_i        = '0;
    cyc          = 0;
    limit        = 0;
    stall_cyc    = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    mem_count    = 0;
    lcg_state    = 42158;
    build_table();
    limit = 4 * tbl_wen.size() + 100;
    repeat (10) @(posedge tcb);
    arst_n_i <= 1'b1;
    @(negedge tcb);
    // idle bus after reset
    if (rdy_o !== 1'b1) begin
      report_mismatch("rdy_o", 32'h1, tcb_pkg::dat_t'(rdy_o));
    end
    if (err_o !== 1'b0) begin
      report_mismatch("err_o", 32'h0, tcb_pkg::dat_t'(err_o));
    end
    @(posedge tcb);
    drive_table();
    while (due_q.size() != 0) begin
      @(posedge tcb);
    end
    if (stall_cyc == 0) begin
      fail_cnt++;
      $display("memory never dropped rdy during the stalled burst");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: compile.f
hw/tcb_pkg.sv
hw/tcb_map_pkg.sv
hw/tcb_dec.sv
hw/tcb_mem_sub.sv
hw/tcb_cfg_regs.sv
hw/tcb_sub_top.sv
sim/tcb_sub_tb.sv

// File: Makefile
# Verilator build and run of the TCB subsystem testbench

TOP := tcb_sub_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search the log for the pass message"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
